// ==== rtl/imu_types_pkg.sv ====
// Sensor payload types for the two hand sensors, imported by capture, packer and testbench
package imu_types_pkg;

    // Sensor 1 is the right hand, sensor 2 the left hand
    localparam int NUM_SENSORS = 2;

    // Orientation quaternion as delivered by the sensor hub
    typedef struct packed {
        logic signed [15:0] w;
        logic signed [15:0] x;
        logic signed [15:0] y;
        logic signed [15:0] z;
    } quat_t;   // 64 bits

    // Calibrated angular rate, one word per axis
    typedef struct packed {
        logic signed [15:0] x;
        logic signed [15:0] y;
        logic signed [15:0] z;
    } gyro_t;   // 48 bits

    // Raw 16-bit sensor units throughout
    // Scaling is left to the microcontroller

endpackage

// ==== rtl/frame_pkg.sv ====
// Report frame layout shared by the packer, the streamer and the testbench model
package frame_pkg;

    localparam int FRAME_BYTES  = 32;
    localparam int SENSOR_BYTES = 15;  // 8 quat + 6 gyro + 1 flag byte
    localparam int OFS_BUTTONS  = 30;  // Kick at 30, calibrate at 31

    // Per sensor, base s*SENSOR_BYTES
    //   +0..+7   quat w, x, y, z, high byte first
    //   +8..+13  gyro x, y, z, high byte first
    //   +14      flags, bit 0 quat valid, bit 1 gyro valid
    // Byte 30 bit 0 kick, byte 31 bit 0 calibrate
    // Unused flag bits are sent as zero

    // Whole frame, index 0 goes out first
    typedef logic [7:0] frame_t [FRAME_BYTES];

    // Position of the byte currently on the SPI side
    typedef logic [$clog2(FRAME_BYTES)-1:0] byte_idx_t;

endpackage

// ==== rtl/snapshot_if.sv ====
// Snapshot handshake between the capture stage and the frame packer, one producer one consumer
`timescale 1ns/1ps

interface snapshot_if;
    import imu_types_pkg::*;

    quat_t                  quat [NUM_SENSORS];  // Latest quaternion per sensor
    gyro_t                  gyro [NUM_SENSORS];  // Latest gyro per sensor
    logic [NUM_SENSORS-1:0] quat_ok;             // Sticky, seen at least once
    logic [NUM_SENSORS-1:0] gyro_ok;
    logic                   kick;                // Button flags pending for next frame
    logic                   calibrate;
    logic                   ready;               // Level, new snapshot waiting
    logic                   ack;                 // One-cycle pulse, only while ready

    // Capture side
    modport producer (
        output quat, gyro, quat_ok, gyro_ok,
        output kick, calibrate, ready,
        input  ack
    );

    // Packer side
    modport consumer (
        input  quat, gyro, quat_ok, gyro_ok,
        input  kick, calibrate, ready,
        output ack
    );

endinterface

// ==== rtl/sample_hold.sv ====
// Holding register with sticky valid flag, instantiated once per sensor payload in capture
`timescale 1ns/1ps

module sample_hold #(
    parameter type payload_t = logic [15:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     strobe,   // Sensor delivered a new sample
    input  payload_t din,
    output payload_t dout,     // Latest sample, holds between strobes
    output logic     held      // Set by first strobe, only reset clears it
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dout <= '0;
            held <= 1'b0;
        end else if (strobe) begin
            dout <= din;
            held <= 1'b1;   // Sticky
        end
    end

    // Valid flag may only rise once per reset
    a_held_sticky: assert property (
        @(posedge clk) disable iff (!rst_n)
        held |=> held
    ) else $error("sample_hold: held flag dropped outside reset");

endmodule

// ==== rtl/sensor_capture.sv ====
// Stage one, latches sensor samples and button pulses and raises ready for the packer
`timescale 1ns/1ps

module sensor_capture (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic [imu_types_pkg::NUM_SENSORS-1:0] quat_strobe,
    input  logic [imu_types_pkg::NUM_SENSORS-1:0] gyro_strobe,
    input  imu_types_pkg::quat_t                  quat_in [imu_types_pkg::NUM_SENSORS],
    input  imu_types_pkg::gyro_t                  gyro_in [imu_types_pkg::NUM_SENSORS],
    input  logic                                  kick_pulse,
    input  logic                                  calibrate_pulse,
    snapshot_if.producer                          snap
);
    import imu_types_pkg::*;

    logic new_data;   // Anything worth a fresh frame this cycle
    logic kick_q;
    logic calib_q;
    logic ready_q;

    // One quaternion and one gyro hold per sensor
    for (genvar s = 0; s < NUM_SENSORS; s++) begin : g_sensor
        sample_hold #(.payload_t(quat_t)) u_quat_hold (
            .clk    (clk),
            .rst_n  (rst_n),
            .strobe (quat_strobe[s]),
            .din    (quat_in[s]),
            .dout   (snap.quat[s]),
            .held   (snap.quat_ok[s])
        );

        sample_hold #(.payload_t(gyro_t)) u_gyro_hold (
            .clk    (clk),
            .rst_n  (rst_n),
            .strobe (gyro_strobe[s]),
            .din    (gyro_in[s]),
            .dout   (snap.gyro[s]),
            .held   (snap.gyro_ok[s])
        );
    end

    assign new_data = (|quat_strobe) | (|gyro_strobe) | kick_pulse | calibrate_pulse;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            kick_q  <= 1'b0;
            calib_q <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            // A pulse in the ack cycle survives for the following frame
            kick_q  <= kick_pulse | (kick_q & ~snap.ack);
            calib_q <= calibrate_pulse | (calib_q & ~snap.ack);
            // Ack drops ready unless fresh data lands on the same edge
            ready_q <= new_data | (ready_q & ~snap.ack);
        end
    end

    assign snap.kick      = kick_q;
    assign snap.calibrate = calib_q;
    assign snap.ready     = ready_q;

    // Packer must only take a snapshot that is on offer
    a_ack_needs_ready: assert property (
        @(posedge clk) disable iff (!rst_n)
        snap.ack |-> snap.ready
    ) else $error("sensor_capture: ack while ready low");

endmodule

// ==== rtl/frame_packer.sv ====
// Stage two, maps the snapshot into the 32-byte report frame and hands it to the streamer
`timescale 1ns/1ps

module frame_packer (
    snapshot_if.consumer     snap,
    input  logic             busy,    // Streamer still sending previous frame
    output frame_pkg::frame_t frame,
    output logic             load     // Streamer copies frame this cycle
);
    import imu_types_pkg::*;
    import frame_pkg::*;

    // Take the snapshot as soon as the streamer is free
    assign load     = snap.ready & ~busy;
    assign snap.ack = load;   // Same cycle, capture releases its buttons

    always_comb begin
        for (int s = 0; s < NUM_SENSORS; s++) begin
            // Quaternion, big endian per component
            frame[s*SENSOR_BYTES + 0]  = snap.quat[s].w[15:8];
            frame[s*SENSOR_BYTES + 1]  = snap.quat[s].w[7:0];
            frame[s*SENSOR_BYTES + 2]  = snap.quat[s].x[15:8];
            frame[s*SENSOR_BYTES + 3]  = snap.quat[s].x[7:0];
            frame[s*SENSOR_BYTES + 4]  = snap.quat[s].y[15:8];
            frame[s*SENSOR_BYTES + 5]  = snap.quat[s].y[7:0];
            frame[s*SENSOR_BYTES + 6]  = snap.quat[s].z[15:8];
            frame[s*SENSOR_BYTES + 7]  = snap.quat[s].z[7:0];

            // Gyro axes
            frame[s*SENSOR_BYTES + 8]  = snap.gyro[s].x[15:8];
            frame[s*SENSOR_BYTES + 9]  = snap.gyro[s].x[7:0];
            frame[s*SENSOR_BYTES + 10] = snap.gyro[s].y[15:8];
            frame[s*SENSOR_BYTES + 11] = snap.gyro[s].y[7:0];
            frame[s*SENSOR_BYTES + 12] = snap.gyro[s].z[15:8];
            frame[s*SENSOR_BYTES + 13] = snap.gyro[s].z[7:0];

            // Flag byte closes each sensor block
            frame[s*SENSOR_BYTES + 14] = {6'b0, snap.gyro_ok[s], snap.quat_ok[s]};
        end

        // Button bytes at the tail
        frame[OFS_BUTTONS]     = {7'b0, snap.kick};
        frame[OFS_BUTTONS + 1] = {7'b0, snap.calibrate};
    end

endmodule

// ==== rtl/byte_streamer.sv ====
// Stage three, holds one report frame and shows its bytes to the SPI slave under tx_next pacing
`timescale 1ns/1ps

module byte_streamer (
    input  logic              clk,
    input  logic              rst_n,
    input  frame_pkg::frame_t frame,
    input  logic              load,      // Copy frame, start at byte 0
    input  logic              tx_next,   // SPI side consumed shown byte
    output logic [7:0]        tx_byte,
    output logic              tx_valid,
    output logic              tx_first,  // Byte 0 on display
    output logic              busy
);
    import frame_pkg::*;

    frame_t    buf_q;   // Frame being sent
    byte_idx_t idx_q;
    logic      busy_q;

    // Payload copy, taken on load
    always_ff @(posedge clk) begin
        if (load) begin
            buf_q <= frame;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            idx_q  <= '0;
        end else if (load) begin
            busy_q <= 1'b1;
            idx_q  <= '0;
        end else if (busy_q && tx_next) begin
            if (idx_q == byte_idx_t'(FRAME_BYTES - 1)) begin
                busy_q <= 1'b0;   // Last byte taken
                idx_q  <= '0;
            end else begin
                idx_q <= idx_q + 1'b1;
            end
        end
    end

    assign tx_byte  = buf_q[idx_q];
    assign tx_valid = busy_q;
    assign tx_first = busy_q && (idx_q == '0);
    assign busy     = busy_q;

    // Packer has to wait for the end of the current frame
    a_no_load_busy: assert property (
        @(posedge clk) disable iff (!rst_n)
        load |-> !busy_q
    ) else $error("byte_streamer: load while busy");

    // Back-pressure, shown byte holds until consumed
    a_hold_byte: assert property (
        @(posedge clk) disable iff (!rst_n)
        (tx_valid && !tx_next) |=> ($stable(tx_byte) && $stable(tx_first))
    ) else $error("byte_streamer: tx_byte moved without tx_next");

endmodule

// ==== rtl/imu_report_top.sv ====
// Top level of the report path, two sensors and buttons in, frame bytes out to the SPI slave
`timescale 1ns/1ps

module imu_report_top (
    input  logic                 clk,
    input  logic                 rst_n,
    // Sensor 1, right hand
    input  logic                 quat1_valid,
    input  imu_types_pkg::quat_t quat1,
    input  logic                 gyro1_valid,
    input  imu_types_pkg::gyro_t gyro1,
    // Sensor 2, left hand
    input  logic                 quat2_valid,
    input  imu_types_pkg::quat_t quat2,
    input  logic                 gyro2_valid,
    input  imu_types_pkg::gyro_t gyro2,
    input  logic                 calibrate_btn_pulse,
    input  logic                 kick_btn_pulse,
    // SPI slave side
    input  logic                 tx_next,
    output logic [7:0]           tx_byte,
    output logic                 tx_valid,
    output logic                 tx_first
);
    import imu_types_pkg::*;
    import frame_pkg::*;

    logic [NUM_SENSORS-1:0] quat_strobe;
    logic [NUM_SENSORS-1:0] gyro_strobe;
    quat_t                  quat_in [NUM_SENSORS];
    gyro_t                  gyro_in [NUM_SENSORS];
    frame_t                 frame;        // Packer to streamer
    logic                   load;
    logic                   busy;

    snapshot_if snap ();

    // Index 0 is sensor 1, goes first in the frame
    assign quat_strobe = {quat2_valid, quat1_valid};
    assign gyro_strobe = {gyro2_valid, gyro1_valid};
    assign quat_in[0]  = quat1;
    assign quat_in[1]  = quat2;
    assign gyro_in[0]  = gyro1;
    assign gyro_in[1]  = gyro2;

    sensor_capture u_capture (
        .clk (clk), .rst_n (rst_n),
        .quat_strobe (quat_strobe), .gyro_strobe (gyro_strobe),
        .quat_in (quat_in), .gyro_in (gyro_in),
        .kick_pulse (kick_btn_pulse), .calibrate_pulse (calibrate_btn_pulse),
        .snap (snap.producer)
    );

    frame_packer u_packer (.snap (snap.consumer), .busy (busy), .frame (frame), .load (load));

    byte_streamer u_streamer (
        .clk (clk), .rst_n (rst_n), .frame (frame), .load (load), .tx_next (tx_next),
        .tx_byte (tx_byte), .tx_valid (tx_valid), .tx_first (tx_first), .busy (busy)
    );

endmodule

// ==== verification/imu_report_tb.sv ====
// Randomized testbench for the IMU report path, streams every frame and compares it with a model
`timescale 1ns/1ps

module imu_report_tb;
    import imu_types_pkg::*;
    import frame_pkg::*;

    localparam int WAIT_LIMIT = 50;   // Cycles before a wait gives up
    localparam int ROUNDS     = 40;

    logic       clk;
    logic       rst_n;
    logic       quat1_valid;
    quat_t      quat1;
    logic       gyro1_valid;
    gyro_t      gyro1;
    logic       quat2_valid;
    quat_t      quat2;
    logic       gyro2_valid;
    gyro_t      gyro2;
    logic       calibrate_btn_pulse;
    logic       kick_btn_pulse;
    logic       tx_next;
    logic [7:0] tx_byte;
    logic       tx_valid;
    logic       tx_first;

    // Model of the capture stage
    quat_t                  m_quat [NUM_SENSORS];
    gyro_t                  m_gyro [NUM_SENSORS];
    logic [NUM_SENSORS-1:0] m_quat_ok;   // Sticky per sensor
    logic [NUM_SENSORS-1:0] m_gyro_ok;
    logic                   m_kick;      // Pending until the next load
    logic                   m_calib;
    frame_t                 exp_frame;

    imu_report_top u_dut (
        .clk (clk), .rst_n (rst_n),
        .quat1_valid (quat1_valid), .quat1 (quat1), .gyro1_valid (gyro1_valid), .gyro1 (gyro1),
        .quat2_valid (quat2_valid), .quat2 (quat2), .gyro2_valid (gyro2_valid), .gyro2 (gyro2),
        .calibrate_btn_pulse (calibrate_btn_pulse), .kick_btn_pulse (kick_btn_pulse),
        .tx_next (tx_next), .tx_byte (tx_byte), .tx_valid (tx_valid), .tx_first (tx_first)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;   // 8 ns period
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("test failed");
        $fatal(1, "Simulation stopped at first error");
    endtask

    task automatic check_byte(input byte_idx_t idx, input logic [7:0] exp, input logic [7:0] got);
        if (got !== exp) begin
            abort_run($sformatf("Error: tx_byte[%0d] expected %h got %h", idx, exp, got));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            abort_run($sformatf("Error: %s expected %h got %h", name, exp, got));
        end
    endtask

    task automatic idle_inputs();
        quat1_valid         = 1'b0;
        gyro1_valid         = 1'b0;
        quat2_valid         = 1'b0;
        gyro2_valid         = 1'b0;
        kick_btn_pulse      = 1'b0;
        calibrate_btn_pulse = 1'b0;
        tx_next             = 1'b0;
    endtask

    // One cycle of random strobes and buttons, model follows
    task automatic drive_round();
        logic [3:0] stb;
        quat_t      q [NUM_SENSORS];
        gyro_t      g [NUM_SENSORS];
        logic       kick;
        logic       calib;
        stb   = 4'($urandom_range(1, 15));   // At least one sensor strobe
        kick  = ($urandom_range(0, 3) == 0);
        calib = ($urandom_range(0, 3) == 0);
        for (int s = 0; s < NUM_SENSORS; s++) begin
            q[s] = {$urandom(), $urandom()};
            g[s] = {$urandom(), 16'($urandom())};
            if (stb[s]) begin
                m_quat[s]    = q[s];
                m_quat_ok[s] = 1'b1;
            end
            if (stb[s + 2]) begin   // Upper strobe bits are gyro
                m_gyro[s]    = g[s];
                m_gyro_ok[s] = 1'b1;
            end
        end
        m_kick  = m_kick | kick;
        m_calib = m_calib | calib;
        quat1_valid         = stb[0];
        quat2_valid         = stb[1];
        gyro1_valid         = stb[2];
        gyro2_valid         = stb[3];
        quat1               = q[0];
        quat2               = q[1];
        gyro1               = g[0];
        gyro2               = g[1];
        kick_btn_pulse      = kick;
        calibrate_btn_pulse = calib;
        @(posedge clk);
        #1;
        idle_inputs();
    endtask

    // Expected frame from the model, load also releases the buttons
    task automatic take_snapshot(output frame_t f);
        logic [15:0] words [7];
        int          base;
        for (int s = 0; s < NUM_SENSORS; s++) begin
            base  = s * SENSOR_BYTES;
            words = '{m_quat[s].w, m_quat[s].x, m_quat[s].y, m_quat[s].z,
                      m_gyro[s].x, m_gyro[s].y, m_gyro[s].z};
            for (int k = 0; k < 7; k++) begin
                f[base + 2*k]     = words[k][15:8];   // MSB first
                f[base + 2*k + 1] = words[k][7:0];
            end
            f[base + 14] = 8'(m_quat_ok[s]) | (8'(m_gyro_ok[s]) << 1);
        end
        f[OFS_BUTTONS]     = 8'(m_kick);
        f[OFS_BUTTONS + 1] = 8'(m_calib);
        m_kick  = 1'b0;
        m_calib = 1'b0;
    endtask

    task automatic wait_valid();
        int cycles;
        cycles = 0;
        while (tx_valid !== 1'b1) begin
            if (cycles == WAIT_LIMIT) begin
                abort_run("Timeout while waiting for tx_valid to start the next frame");
            end
            @(posedge clk);
            #1;
            cycles++;
        end
    endtask

    // Whole frame with random pacing, optional new round at byte overlap_at
    task automatic read_frame(input frame_t f, input int overlap_at);
        int gap;
        wait_valid();
        for (int i = 0; i < FRAME_BYTES; i++) begin
            if (i == overlap_at) begin
                drive_round();   // Capture updates while this frame streams
            end
            check_flag("tx_valid", 1'b1, tx_valid);
            check_flag("tx_first", i == 0, tx_first);
            check_byte(byte_idx_t'(i), f[i], tx_byte);
            gap = $urandom_range(0, 3);
            repeat (gap) begin
                @(posedge clk);
                #1;
                check_byte(byte_idx_t'(i), f[i], tx_byte);   // Back-pressure hold
                check_flag("tx_first", i == 0, tx_first);
            end
            tx_next = 1'b1;
            @(posedge clk);
            #1;
            tx_next = 1'b0;
        end
        check_flag("tx_valid", 1'b0, tx_valid);   // Low right after last byte
    endtask

    task automatic check_quiet(input int cycles);
        repeat (cycles) begin
            check_flag("tx_valid", 1'b0, tx_valid);
            check_flag("tx_first", 1'b0, tx_first);
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        void'($urandom(32'hb664));
        rst_n = 1'b0;
        idle_inputs();
        quat1 = '0;
        quat2 = '0;
        gyro1 = '0;
        gyro2 = '0;
        for (int s = 0; s < NUM_SENSORS; s++) begin
            m_quat[s] = '0;
            m_gyro[s] = '0;
        end
        m_quat_ok = '0;
        m_gyro_ok = '0;
        m_kick    = 1'b0;
        m_calib   = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_quiet(20);   // Nothing streams without input
        for (int r = 0; r < ROUNDS; r++) begin
            drive_round();
            take_snapshot(exp_frame);
            if (r % 5 == 4) begin
                read_frame(exp_frame, $urandom_range(1, 30));
                take_snapshot(exp_frame);   // Latest state after the mid-frame round
                read_frame(exp_frame, -1);
            end else if (r % 5 == 2) begin
                drive_round();   // Lands on the ack edge, buttons and ready must survive
                read_frame(exp_frame, -1);
                take_snapshot(exp_frame);
                read_frame(exp_frame, -1);
            end else begin
                read_frame(exp_frame, -1);
            end
            check_quiet(3);   // No extra frame
        end
        $display("test passed");
        $finish;
    end

endmodule

// ==== tb.f ====
rtl/imu_types_pkg.sv
rtl/frame_pkg.sv
rtl/snapshot_if.sv
rtl/sample_hold.sv
rtl/sensor_capture.sv
rtl/frame_packer.sv
rtl/byte_streamer.sv
rtl/imu_report_top.sv
verification/imu_report_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module imu_report_tb -f tb.f -o imu_report_sim
out=$(./obj_dir/imu_report_sim) || true
echo "$out"
echo "$out" | grep -q "test passed"
